/* logic/nn_consts.svh */
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

`define NN_NUM_INPUTS 8
`define NN_NUM_NEURONS 4
`define NN_DATA_WIDTH 16
`define NN_ADDR_WIDTH 8
`define NN_BUS_WIDTH 32

// Neuron-major table, neuron 0 input 0 in the lowest word
`define NN_WEIGHTS { \
	16'sd7,  -16'sd20, 16'sd16,  -16'sd4,  -16'sd11, 16'sd9,   16'sd16, -16'sd1,  \
	16'sd20, -16'sd5,  -16'sd9,  -16'sd4,  -16'sd3,  16'sd11,  -16'sd9, -16'sd3,  \
	16'sd14, -16'sd15, 16'sd4,   16'sd6,   16'sd14,  16'sd23,  16'sd6,  16'sd0,   \
	16'sd8,  -16'sd5,  -16'sd2,  -16'sd6,  -16'sd6,  16'sd13,  16'sd15, 16'sd12   \
}

// Bias of neuron 0 in the lowest word
`define NN_BIASES {-16'sd30, 16'sd0, 16'sd5, -16'sd1}

`endif

/* logic/fixedPointPkg.sv */
`include "nn_consts.svh"

package fixedPointPkg;

	// Activations and results, wrapping 16-bit words
	typedef logic [`NN_DATA_WIDTH-1:0] activation_t;

	typedef logic signed [`NN_DATA_WIDTH-1:0] weight_t;

	// Layer engine state
	typedef enum logic
	{
		stIdle,
		stBusy
	} layerState_e;

endpackage

/* logic/busPkg.sv */
`include "nn_consts.svh"

package busPkg;

	typedef enum logic [1:0]
	{
		respOkay   = 2'b00,
		respSlvErr = 2'b10
	} axiResp_e;

	// Byte offsets of the register map
	typedef enum logic [`NN_ADDR_WIDTH-1:0]
	{
		regAct0   = 'h00, // Activations 0..7, one word each
		regCtrl   = 'h20,
		regStatus = 'h24, // Bit 0 busy, bit 1 done
		regRes0   = 'h40  // Results 0..3
	} regOffset_e;

endpackage

/* logic/denseNeuron.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module denseNeuron #(
	parameter logic [`NN_NUM_INPUTS*`NN_DATA_WIDTH-1:0] WEIGHTS = '0,
	parameter fixedPointPkg::weight_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [`NN_NUM_INPUTS-1:0] act,
	output fixedPointPkg::activation_t result
);

	fixedPointPkg::activation_t [`NN_NUM_INPUTS-1:0] actReg;
	fixedPointPkg::activation_t sumReg;
	fixedPointPkg::activation_t sumNext;

	// Weighted sum, each product cut to 16 bits before adding
	always_comb
	begin
		fixedPointPkg::activation_t prod;
		sumNext = BIAS;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			prod = actReg[i] * WEIGHTS[i*`NN_DATA_WIDTH +: `NN_DATA_WIDTH];
			sumNext = sumNext + prod; // Wraps mod 2^16
		end
	end

	always_ff @(posedge clk)
	begin
		actReg <= act; // Stage 1 capture
		sumReg <= sumNext;
	end

	// ReLU stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (sumReg[`NN_DATA_WIDTH-1])
		begin
			result <= '0;
		end
		else
		begin
			result <= sumReg;
		end
	end

	assertReluNonNegative: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(result) |-> !result[`NN_DATA_WIDTH-1]
	);

endmodule

/* logic/denseLayer.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module denseLayer #(
	parameter logic [`NN_NUM_NEURONS*`NN_NUM_INPUTS*`NN_DATA_WIDTH-1:0] WEIGHTS = '0,
	parameter logic [`NN_NUM_NEURONS*`NN_DATA_WIDTH-1:0] BIASES = '0
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [`NN_NUM_INPUTS-1:0] actVec,
	input logic start,
	output fixedPointPkg::activation_t [`NN_NUM_NEURONS-1:0] resVec,
	output logic resValid
);

	localparam int ROW_W = `NN_NUM_INPUTS * `NN_DATA_WIDTH;

	logic [2:0] validPipe;

	for (genvar n = 0; n < `NN_NUM_NEURONS; n++)
	begin : gNeuron
		denseNeuron #(
			.WEIGHTS(WEIGHTS[n*ROW_W +: ROW_W]),
			.BIAS(BIASES[n*`NN_DATA_WIDTH +: `NN_DATA_WIDTH])
		) uNeuron (
			.clk(clk),
			.reset(reset),
			.act(actVec),
			.result(resVec[n])
		);
	end

	// Tracks start through capture, sum and ReLU
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], start};
		end
	end

	assign resValid = validPipe[2];

	assertValidLatency: assert property (
		@(posedge clk) disable iff (reset)
		start |-> ##3 resValid
	);

	assertNoSpuriousValid: assert property (
		@(posedge clk) disable iff (reset)
		resValid |-> $past(start, 3)
	);

endmodule

/* logic/axiLiteRegs.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module axiLiteRegs (
	input logic clk,
	input logic reset,
	input logic [`NN_ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`NN_BUS_WIDTH-1:0] wdata,
	input logic [`NN_BUS_WIDTH/8-1:0] wstrb, // Ignored, full-word writes
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`NN_ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`NN_BUS_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output fixedPointPkg::activation_t [`NN_NUM_INPUTS-1:0] actVec,
	output logic start,
	input fixedPointPkg::activation_t [`NN_NUM_NEURONS-1:0] resVec,
	input logic resValid
);

	localparam int ACT_IDX_W = $clog2(`NN_NUM_INPUTS);
	localparam int RES_IDX_W = $clog2(`NN_NUM_NEURONS);

	fixedPointPkg::layerState_e state;
	fixedPointPkg::activation_t [`NN_NUM_NEURONS-1:0] resReg;
	logic done;
	logic busy;
	logic writeFire;
	logic [`NN_BUS_WIDTH-1:0] rdNext;
	logic rdErr;

	function automatic logic isActAddr(input logic [`NN_ADDR_WIDTH-1:0] addr);
		return addr[1:0] == 2'b00 && addr < busPkg::regAct0 + 4 * `NN_NUM_INPUTS;
	endfunction

	function automatic logic isResAddr(input logic [`NN_ADDR_WIDTH-1:0] addr);
		return addr[1:0] == 2'b00 && addr >= busPkg::regRes0
			&& addr < busPkg::regRes0 + 4 * `NN_NUM_NEURONS;
	endfunction

	assign busy = (state == fixedPointPkg::stBusy) || start; // Start cycle counts as busy
	assign writeFire = awready && awvalid && wvalid;
	assign wready = awready;

	// Write channel, AW and W taken together
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= busPkg::respOkay;
			start <= 1'b0;
			actVec <= '0;
		end
		else
		begin
			start <= 1'b0;
			awready <= awvalid && wvalid && !bvalid && !awready;
			if (writeFire)
			begin
				bvalid <= 1'b1;
				bresp <= busPkg::respOkay;
				if (isActAddr(awaddr))
				begin
					if (busy)
						bresp <= busPkg::respSlvErr;
					else
						actVec[awaddr[ACT_IDX_W+1:2]] <= wdata[`NN_DATA_WIDTH-1:0];
				end
				else if (awaddr == busPkg::regCtrl)
				begin
					if (wdata[0] && busy)
						bresp <= busPkg::respSlvErr;
					else if (wdata[0])
						start <= 1'b1;
				end
				else
				begin
					bresp <= busPkg::respSlvErr; // Status, results, unmapped
				end
			end
			else if (bvalid && bready)
			begin
				bvalid <= 1'b0;
			end
		end
	end

	always_comb
	begin
		rdNext = '0;
		rdErr = 1'b0;
		if (isActAddr(araddr))
			rdNext[`NN_DATA_WIDTH-1:0] = actVec[araddr[ACT_IDX_W+1:2]];
		else if (isResAddr(araddr))
			rdNext[`NN_DATA_WIDTH-1:0] = resReg[araddr[RES_IDX_W+1:2]];
		else if (araddr == busPkg::regStatus)
			rdNext[1:0] = {done, busy};
		else if (araddr != busPkg::regCtrl)
			rdErr = 1'b1; // Unmapped reads as zero
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= busPkg::respOkay;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (arready && arvalid)
			begin
				rvalid <= 1'b1;
				rdata <= rdNext;
				rresp <= rdErr ? busPkg::respSlvErr : busPkg::respOkay;
			end
			else if (rvalid && rready)
			begin
				rvalid <= 1'b0;
			end
		end
	end

	// Engine control and result capture
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= fixedPointPkg::stIdle;
			done <= 1'b0;
			resReg <= '0;
		end
		else
		begin
			if (resValid)
				resReg <= resVec; // Latched even under back-pressure
			case (state)
				fixedPointPkg::stIdle:
					if (start)
					begin
						state <= fixedPointPkg::stBusy;
						done <= 1'b0;
					end
				fixedPointPkg::stBusy:
					if (resValid)
					begin
						state <= fixedPointPkg::stIdle;
						done <= 1'b1;
					end
				default: state <= fixedPointPkg::stIdle;
			endcase
		end
	end

	assertBvalidHeld: assert property (
		@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp)
	);

	assertNoAcceptWhilePending: assert property (
		@(posedge clk) disable iff (reset)
		awready |-> !bvalid
	);

endmodule

/* logic/neuralLayerTop.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module neuralLayerTop (
	input logic clk,
	input logic reset,
	input logic [`NN_ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`NN_BUS_WIDTH-1:0] wdata,
	input logic [`NN_BUS_WIDTH/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`NN_ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`NN_BUS_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	fixedPointPkg::activation_t [`NN_NUM_INPUTS-1:0] actVec;
	fixedPointPkg::activation_t [`NN_NUM_NEURONS-1:0] resVec;
	logic start;
	logic resValid;

	axiLiteRegs uAxiLiteRegs (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.actVec(actVec),
		.start(start),
		.resVec(resVec),
		.resValid(resValid)
	);

	// Fixed weights and biases
	denseLayer #(
		.WEIGHTS(`NN_WEIGHTS),
		.BIASES(`NN_BIASES)
	) uDenseLayer (
		.clk(clk),
		.reset(reset),
		.actVec(actVec),
		.start(start),
		.resVec(resVec),
		.resValid(resValid)
	);

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#2 reset = 1'b0;
	end

endmodule

/* tests/neuralLayerTb.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module neuralLayerTb;

	localparam int NUM_ROWS = 6;
	localparam int CLK_NS = 20;
	localparam int ROW_NS = 100 * CLK_NS; // About 30 transfers of 3 cycles each
	localparam int WATCHDOG_NS = (NUM_ROWS + 2) * ROW_NS + 2000;
	localparam logic [`NN_NUM_NEURONS*`NN_NUM_INPUTS*`NN_DATA_WIDTH-1:0] WEIGHT_TABLE =
		`NN_WEIGHTS;
	localparam logic [`NN_NUM_NEURONS*`NN_DATA_WIDTH-1:0] BIAS_TABLE = `NN_BIASES;

	logic clk;
	logic reset;
	logic [`NN_ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`NN_BUS_WIDTH-1:0] wdata;
	logic [`NN_BUS_WIDTH/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`NN_ADDR_WIDTH-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`NN_BUS_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [`NN_DATA_WIDTH-1:0] stimTable [NUM_ROWS][`NN_NUM_INPUTS];
	logic [`NN_DATA_WIDTH-1:0] expTable [NUM_ROWS][`NN_NUM_NEURONS];
	logic [31:0] rngState;

	clockGen uClockGen (
		.clk(clk),
		.reset(reset)
	);

	neuralLayerTop u_neuralLayerTop (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Products cut to 16 bits, sum wraps, ReLU on bit 15
	function automatic logic [`NN_DATA_WIDTH-1:0] modelNeuron(input int row, input int n);
		logic [`NN_DATA_WIDTH-1:0] sum;
		logic [`NN_DATA_WIDTH-1:0] prod;
		sum = BIAS_TABLE[n*`NN_DATA_WIDTH +: `NN_DATA_WIDTH];
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			prod = stimTable[row][i]
				* WEIGHT_TABLE[(n*`NN_NUM_INPUTS+i)*`NN_DATA_WIDTH +: `NN_DATA_WIDTH];
			sum = sum + prod;
		end
		return sum[`NN_DATA_WIDTH-1] ? '0 : sum;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
			$display("Regression failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Starts and ends 2 ns after a rising edge
	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data, input int stall,
		output logic [1:0] resp);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (stall == 0);
		@(negedge clk);
		while (!awready) @(negedge clk);
		checkValue("wready", 1, wready); // Rises together with awready
		@(posedge clk);
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		resp = bresp;
		repeat (stall)
		begin
			@(negedge clk);
			checkValue("bvalid held", 1, bvalid);
			checkValue("bresp held", resp, bresp);
		end
		if (stall > 0)
		begin
			@(posedge clk);
			#2 bready = 1'b1;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic axiRead(input logic [7:0] addr, input int stall, output logic [31:0] data,
		output logic [1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = (stall == 0);
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#2 arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		data = rdata;
		resp = rresp;
		repeat (stall)
		begin
			@(negedge clk);
			checkValue("rvalid held", 1, rvalid);
			checkValue("rdata held", data, rdata);
		end
		if (stall > 0)
		begin
			@(posedge clk);
			#2 rready = 1'b1;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic checkAfterReset;
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(busPkg::regStatus, 0, data, resp);
		checkValue("rresp status", busPkg::respOkay, resp);
		checkValue("rdata status", 0, data);
		for (int n = 0; n < `NN_NUM_NEURONS; n++)
		begin
			axiRead(8'(busPkg::regRes0 + 4 * n), 0, data, resp);
			checkValue("rresp result", busPkg::respOkay, resp);
			checkValue($sformatf("rdata result %0d", n), 0, data);
		end
	endtask

	task automatic waitDone(input int row);
		logic [31:0] data;
		logic [1:0] resp;
		logic doneSeen;
		doneSeen = 1'b0;
		for (int poll = 0; poll < 20 && !doneSeen; poll++)
		begin
			axiRead(busPkg::regStatus, 0, data, resp);
			checkValue("rresp status", busPkg::respOkay, resp);
			doneSeen = data[1];
		end
		assert (doneSeen)
		else
		begin
			$display("Status never showed done for row %0d", row);
			$display("Regression failed");
			$fatal(1, "Layer did not finish");
		end
	endtask

	task automatic readResults(input int row, input int stall);
		logic [31:0] data;
		logic [1:0] resp;
		for (int n = 0; n < `NN_NUM_NEURONS; n++)
		begin
			axiRead(8'(busPkg::regRes0 + 4 * n), stall, data, resp);
			checkValue("rresp result", busPkg::respOkay, resp);
			checkValue($sformatf("rdata result %0d row %0d", n, row), expTable[row][n], data);
		end
	endtask

	task automatic readActs(input int row);
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			axiRead(8'(busPkg::regAct0 + 4 * i), 0, data, resp);
			checkValue($sformatf("rdata activation %0d", i), stimTable[row][i], data);
		end
	endtask

	task automatic runRow(input int row, input int stall);
		logic [1:0] resp;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			axiWrite(8'(busPkg::regAct0 + 4 * i), stimTable[row][i], 0, resp);
			checkValue("bresp activation", busPkg::respOkay, resp);
		end
		axiWrite(busPkg::regCtrl, 1, stall, resp);
		checkValue("bresp start", busPkg::respOkay, resp);
		waitDone(row);
		readResults(row, stall);
		readActs(row);
	endtask

	// None of these accesses may change state
	task automatic badAccesses;
		logic [31:0] data;
		logic [1:0] resp;
		axiWrite(8'h30, 32'hDEAD, 0, resp);
		checkValue("bresp unmapped write", busPkg::respSlvErr, resp);
		axiRead(8'h30, 0, data, resp);
		checkValue("rresp unmapped read", busPkg::respSlvErr, resp);
		checkValue("rdata unmapped read", 0, data);
		axiWrite(busPkg::regRes0, 32'hBEEF, 0, resp);
		checkValue("bresp result write", busPkg::respSlvErr, resp);
		readResults(NUM_ROWS - 1, 0); // Before the next start overwrites them
		axiWrite(busPkg::regCtrl, 1, 0, resp);
		checkValue("bresp start", busPkg::respOkay, resp);
		axiWrite(busPkg::regAct0, 32'h5A5A, 0, resp); // Layer still busy
		checkValue("bresp write while busy", busPkg::respSlvErr, resp);
		waitDone(NUM_ROWS - 1);
		readResults(NUM_ROWS - 1, 0);
		readActs(NUM_ROWS - 1);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$fatal(1, "Timeout");
	end

	initial
	begin
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '1;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		stimTable[0] = '{default: 16'h0000};
		stimTable[1] = '{default: 16'h0001};
		stimTable[2] = '{16'd3, 16'd1, 16'd4, 16'd1, 16'd5, 16'd9, 16'd2, 16'd6};
		stimTable[3] = '{16'd10, -16'sd7, 16'd25, -16'sd3, 16'd0, 16'd12, -16'sd18, 16'd5};
		// Products and sums well past 16 bits
		stimTable[4] = '{16'h7FFF, 16'h8000, 16'h4000, 16'h7000,
			16'hC000, 16'h1234, 16'h6000, 16'hFFF0};
		rngState = 32'd3;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			rngState = xorshift32(rngState);
			stimTable[5][i] = rngState[15:0];
		end
		for (int r = 0; r < NUM_ROWS; r++)
			for (int n = 0; n < `NN_NUM_NEURONS; n++)
				expTable[r][n] = modelNeuron(r, n);
		wait (reset === 1'b0);
		@(posedge clk);
		#2;
		checkAfterReset();
		for (int r = 0; r < NUM_ROWS; r++)
			runRow(r, 0);
		badAccesses();
		runRow(2, 4); // bready and rready held low
		$display("Regression passed");
		$finish;
	end

endmodule

/* files.f */
+incdir+logic
logic/fixedPointPkg.sv
logic/busPkg.sv
logic/denseNeuron.sv
logic/denseLayer.sv
logic/axiLiteRegs.sv
logic/neuralLayerTop.sv
tests/clockGen.sv
tests/neuralLayerTb.sv

/* Bender.yml */
package:
  name: neural_layer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fixedPointPkg.sv
      - logic/busPkg.sv
      - logic/denseNeuron.sv
      - logic/denseLayer.sv
      - logic/axiLiteRegs.sv
      - logic/neuralLayerTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/clockGen.sv
      - tests/neuralLayerTb.sv
